// ==== hw/datapath_pkg.sv ====
package datapath_pkg;

    // General register count. The top level passes it down to the register file.
    localparam int NUM_REGS = 16;

    typedef logic [31:0] word_t; // One data word.

    // ALU operation codes, equal to instruction bits 31 to 27.
    typedef enum logic [4:0] {
        op_none = 5'd0,
        op_add  = 5'd3,
        op_sub  = 5'd4,
        op_and  = 5'd5,
        op_or   = 5'd6,
        op_shr  = 5'd7,  // Logical shift right.
        op_shra = 5'd8,  // Arithmetic shift right.
        op_shl  = 5'd9,
        op_ror  = 5'd10,
        op_rol  = 5'd11,
        op_mul  = 5'd15, // Signed, full 64-bit product.
        op_neg  = 5'd17,
        op_not  = 5'd18
    } alu_op_t;

    // The Z register, split in the two halves that can drive the bus.
    typedef struct packed {
        word_t hi;
        word_t lo;
    } z_pair_t;

    // Per-cycle control strobes, sampled at the rising clock edge.
    typedef struct packed {
        logic [NUM_REGS-1:0] r_in;  // Load strobes for the general registers.
        logic [NUM_REGS-1:0] r_out; // Bus drive strobes for the general registers.
        logic                pc_in;
        logic                pc_out;
        logic                ir_in;
        logic                mar_in;
        logic                mdr_in;
        logic                mdr_out;
        logic                read;   // MDR takes memory data instead of the bus.
        logic                y_in;
        logic                z_in;
        logic                zhi_out;
        logic                zlo_out;
        logic                inc_pc; // ALU computes bus plus one.
    } ctrl_t;

endpackage

// ==== hw/reg_file.sv ====
`timescale 1ns/1ps

module reg_file #(
    parameter int num_regs = datapath_pkg::NUM_REGS
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [num_regs-1:0]   r_in,     // One load strobe per register.
    input  logic [num_regs-1:0]   r_out,    // One bus drive strobe per register.
    input  datapath_pkg::word_t   bus_data,
    output datapath_pkg::word_t   rf_out
);
    import datapath_pkg::*;

    word_t regs [num_regs];

    // Every register with its load strobe set takes the bus.
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int i = 0; i < num_regs; i++) begin
                if (r_in[i]) begin
                    regs[i] <= bus_data;
                end
            end
        end
    end

    // Selected registers are ORed together.
    // Only one may be selected in a cycle, so this is a plain read port.
    always_comb begin
        rf_out = '0;
        for (int i = 0; i < num_regs; i++) begin
            if (r_out[i]) begin
                rf_out = rf_out | regs[i];
            end
        end
    end

endmodule

// ==== hw/mdr_unit.sv ====
`timescale 1ns/1ps

module mdr_unit (
    input  logic                clk,
    input  logic                rst,
    input  logic                mdr_in,   // Load strobe.
    input  logic                read,     // Take memory data rather than the bus.
    input  datapath_pkg::word_t bus_data,
    input  datapath_pkg::word_t mdatain,  // Memory read data.
    output datapath_pkg::word_t mdr
);

    // Memory data register.
    always_ff @(posedge clk) begin
        if (rst) begin
            mdr <= '0;
        end else if (mdr_in) begin
            if (read) begin
                mdr <= mdatain; // Memory read.
            end else begin
                mdr <= bus_data; // Store path from the bus.
            end
        end
    end

endmodule

// ==== hw/alu.sv ====
`timescale 1ns/1ps

module alu (
    input  datapath_pkg::word_t   a,      // Y register.
    input  datapath_pkg::word_t   b,      // Bus.
    input  datapath_pkg::alu_op_t op,
    input  logic                  inc_pc, // Overrides op with b plus one.
    output datapath_pkg::z_pair_t result
);
    import datapath_pkg::*;

    logic [4:0]  shamt;
    logic [63:0] product;
    logic [63:0] rot_right;
    logic [63:0] rot_left;
    word_t       lo;

    assign shamt = b[4:0]; // Shift amount from the low five bits.

    // Both operands sign-extended, so the low 64 bits are the signed product.
    assign product = {{32{a[31]}}, a} * {{32{b[31]}}, b};

    // Rotates by shifting a doubled copy of the word.
    assign rot_right = {a, a} >> shamt;
    assign rot_left  = {a, a} << shamt;

    always_comb begin
        if (inc_pc) begin
            lo = b + 32'd1; // PC increment.
        end else begin
            case (op)
                op_add: begin
                    lo = a + b;
                end
                op_sub: begin
                    lo = a - b;
                end
                op_and: begin
                    lo = a & b;
                end
                op_or: begin
                    lo = a | b;
                end
                op_shr: begin
                    lo = a >> shamt;
                end
                op_shra: begin
                    lo = $signed(a) >>> shamt;
                end
                op_shl: begin
                    lo = a << shamt;
                end
                op_ror: begin
                    lo = rot_right[31:0];
                end
                op_rol: begin
                    lo = rot_left[63:32];
                end
                op_mul: begin
                    lo = product[31:0];
                end
                op_neg: begin
                    lo = -b; // Y is not used.
                end
                op_not: begin
                    lo = ~b;
                end
                default: begin
                    lo = '0; // op_none and unused codes.
                end
            endcase
        end
    end

    // Multiply fills both halves, everything else is sign-extended into hi.
    always_comb begin
        if (!inc_pc && op == op_mul) begin
            result = product;
        end else begin
            result.hi = {32{lo[31]}};
            result.lo = lo;
        end
    end

endmodule

// ==== hw/bus_mux.sv ====
`timescale 1ns/1ps

module bus_mux (
    input  datapath_pkg::ctrl_t   ctrl,
    input  datapath_pkg::word_t   rf_out, // Already selected by r_out.
    input  datapath_pkg::word_t   pc,
    input  datapath_pkg::word_t   mdr,
    input  datapath_pkg::z_pair_t z,
    output datapath_pkg::word_t   bus_data
);

    logic rf_sel;

    assign rf_sel = |ctrl.r_out; // Any general register on the bus.

    // AND-OR selection. Out strobes are one-hot at most.
    // With no strobe raised the bus reads zero.
    assign bus_data = ({32{rf_sel}}        & rf_out)
                    | ({32{ctrl.pc_out}}   & pc)
                    | ({32{ctrl.mdr_out}}  & mdr)
                    | ({32{ctrl.zhi_out}}  & z.hi)
                    | ({32{ctrl.zlo_out}}  & z.lo);

endmodule

// ==== hw/datapath.sv ====
`timescale 1ns/1ps

module datapath #(
    parameter int num_regs = datapath_pkg::NUM_REGS
) (
    input  logic                  clk,
    input  logic                  rst,
    input  datapath_pkg::ctrl_t   ctrl,     // Control strobes for this cycle.
    input  datapath_pkg::alu_op_t op,
    input  datapath_pkg::word_t   mdatain,  // Memory read data.
    output datapath_pkg::word_t   bus_data,
    output datapath_pkg::word_t   pc,
    output datapath_pkg::word_t   ir,
    output datapath_pkg::word_t   mar,
    output datapath_pkg::word_t   mdr,
    output datapath_pkg::word_t   y,
    output datapath_pkg::z_pair_t z
);
    import datapath_pkg::*;

    word_t   rf_out;
    z_pair_t alu_result;

    // General registers.
    reg_file #(
        .num_regs (num_regs)
    ) u_reg_file (
        .clk      (clk),
        .rst      (rst),
        .r_in     (ctrl.r_in[num_regs-1:0]),
        .r_out    (ctrl.r_out[num_regs-1:0]),
        .bus_data (bus_data),
        .rf_out   (rf_out)
    );

    mdr_unit u_mdr_unit (
        .clk      (clk),
        .rst      (rst),
        .mdr_in   (ctrl.mdr_in),
        .read     (ctrl.read),
        .bus_data (bus_data),
        .mdatain  (mdatain),
        .mdr      (mdr)
    );

    // Y is the first operand, the bus the second.
    alu u_alu (
        .a      (y),
        .b      (bus_data),
        .op     (op),
        .inc_pc (ctrl.inc_pc),
        .result (alu_result)
    );

    bus_mux u_bus_mux (
        .ctrl     (ctrl),
        .rf_out   (rf_out),
        .pc       (pc),
        .mdr      (mdr),
        .z        (z),
        .bus_data (bus_data)
    );

    // Special registers. Each loads at the edge where its strobe is high.
    always_ff @(posedge clk) begin
        if (rst) begin
            pc  <= '0;
            ir  <= '0;
            mar <= '0;
            y   <= '0;
            z   <= '0;
        end else begin
            if (ctrl.pc_in) begin
                pc <= bus_data;
            end
            if (ctrl.ir_in) begin
                ir <= bus_data; // Opcode is presented on ir[31:27].
            end
            if (ctrl.mar_in) begin
                mar <= bus_data; // Memory address.
            end
            if (ctrl.y_in) begin
                y <= bus_data;
            end
            if (ctrl.z_in) begin
                z <= alu_result; // Z takes the ALU, not the bus.
            end
        end
    end

endmodule

// ==== testbench/datapath_chk.sv ====
`timescale 1ns/1ps

module datapath_chk (
    input logic                  clk,
    input logic                  rst,
    input datapath_pkg::ctrl_t   ctrl,
    input datapath_pkg::word_t   pc,
    input datapath_pkg::word_t   ir,
    input datapath_pkg::word_t   mar,
    input datapath_pkg::word_t   mdr,
    input datapath_pkg::word_t   y,
    input datapath_pkg::z_pair_t z
);
    import datapath_pkg::*;

    logic [NUM_REGS+3:0] out_strobes;

    assign out_strobes = {ctrl.r_out, ctrl.pc_out, ctrl.mdr_out, ctrl.zhi_out, ctrl.zlo_out};

    // Single bus source.
    a_one_source: assert property (@(posedge clk) disable iff (rst) $onehot0(out_strobes))
        else $error("More than one out strobe raised in the same cycle");

    // First cycle out of reset.
    a_reset_state: assert property (@(posedge clk) $fell(rst) |->
        (pc == '0 && ir == '0 && mar == '0 && mdr == '0 && y == '0 && z == '0))
        else $error("A register is not zero in the cycle after reset");

endmodule

bind datapath datapath_chk u_chk (
    .clk      (clk),
    .rst      (rst),
    .ctrl     (ctrl),
    .pc       (pc),
    .ir       (ir),
    .mar      (mar),
    .mdr      (mdr),
    .y        (y),
    .z        (z)
);

// ==== testbench/dp_model.svh ====
`ifndef DP_MODEL_SVH
`define DP_MODEL_SVH

// Reference model of the datapath registers, rebuilt from the bus and load rules.
word_t   m_regs [NUM_REGS];
word_t   m_pc;
word_t   m_ir;
word_t   m_mar;
word_t   m_mdr;
word_t   m_y;
z_pair_t m_z;

function automatic void model_reset();
    for (int i = 0; i < NUM_REGS; i++) begin
        m_regs[i] = '0;
    end
    m_pc  = '0;
    m_ir  = '0;
    m_mar = '0;
    m_mdr = '0;
    m_y   = '0;
    m_z   = '0;
endfunction

// Value on the bus for a set of out strobes. At most one source is raised.
function automatic word_t model_bus(ctrl_t c);
    word_t v;
    v = '0;
    if (c.r_out != '0) begin
        for (int i = 0; i < NUM_REGS; i++) begin
            if (c.r_out[i]) begin
                v = m_regs[i];
            end
        end
    end else if (c.pc_out) begin
        v = m_pc;
    end else if (c.mdr_out) begin
        v = m_mdr;
    end else if (c.zhi_out) begin
        v = m_z.hi;
    end else if (c.zlo_out) begin
        v = m_z.lo;
    end
    return v;
endfunction

// Y op bus, or bus plus one for a PC increment.
function automatic z_pair_t model_alu(word_t a, word_t b, alu_op_t o, logic inc);
    z_pair_t r;
    longint  prod;
    int      s;
    word_t   lo;
    s = int'(b[4:0]);
    if (inc) begin
        lo = b + 32'd1;
    end else begin
        case (o)
            op_add:  lo = a + b;
            op_sub:  lo = a - b;
            op_and:  lo = a & b;
            op_or:   lo = a | b;
            op_shr:  lo = a >> s;
            op_shra: lo = $signed(a) >>> s;
            op_shl:  lo = a << s;
            op_ror:  lo = (a >> s) | (a << (32 - s)); // Shift by 32 gives zero.
            op_rol:  lo = (a << s) | (a >> (32 - s));
            op_neg:  lo = 32'd0 - b;
            op_not:  lo = ~b;
            default: lo = '0;
        endcase
    end
    if (!inc && o == op_mul) begin
        prod = longint'($signed(a)) * longint'($signed(b)); // Signed 64-bit product.
        r = z_pair_t'(prod);
    end else begin
        r.hi = lo[31] ? 32'hffff_ffff : 32'h0000_0000;
        r.lo = lo;
    end
    return r;
endfunction

// One rising edge. Z sees Y before Y itself may be reloaded.
function automatic void model_clock(ctrl_t c, alu_op_t o, word_t md);
    word_t   b;
    z_pair_t res;
    b = model_bus(c);
    res = model_alu(m_y, b, o, c.inc_pc);
    for (int i = 0; i < NUM_REGS; i++) begin
        if (c.r_in[i]) begin
            m_regs[i] = b;
        end
    end
    if (c.pc_in) m_pc = b;
    if (c.ir_in) m_ir = b;
    if (c.mar_in) m_mar = b;
    if (c.y_in) m_y = b;
    if (c.mdr_in) m_mdr = c.read ? md : b;
    if (c.z_in) m_z = res;
endfunction

`endif

// ==== testbench/datapath_tb.sv ====
`timescale 1ns/1ps

module datapath_tb;
    import datapath_pkg::*;

    localparam int MAX_CYCLES   = 5000;
    localparam int RANDOM_STEPS = 400;

    logic    clk;
    logic    rst;
    ctrl_t   ctrl;
    alu_op_t op;
    word_t   mdatain;
    word_t   bus_data;
    word_t   pc;
    word_t   ir;
    word_t   mar;
    word_t   mdr;
    word_t   y;
    z_pair_t z;

    int checks;
    int errors;

    alu_op_t op_list [13] = '{op_none, op_add, op_sub, op_and, op_or, op_shr, op_shra,
                              op_shl, op_ror, op_rol, op_mul, op_neg, op_not};

    `include "dp_model.svh"

    datapath #(
        .num_regs (NUM_REGS)
    ) dut (
        .clk      (clk),
        .rst      (rst),
        .ctrl     (ctrl),
        .op       (op),
        .mdatain  (mdatain),
        .bus_data (bus_data),
        .pc       (pc),
        .ir       (ir),
        .mar      (mar),
        .mdr      (mdr),
        .y        (y),
        .z        (z)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk; // 8 ns period.
        end
    end

    task automatic expect_word(string name, word_t got, word_t exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compare_state();
        expect_word("pc", pc, m_pc);
        expect_word("ir", ir, m_ir);
        expect_word("mar", mar, m_mar);
        expect_word("mdr", mdr, m_mdr);
        expect_word("y", y, m_y);
        expect_word("z.hi", z.hi, m_z.hi);
        expect_word("z.lo", z.lo, m_z.lo);
        for (int i = 0; i < NUM_REGS; i++) begin
            expect_word($sformatf("r%0d", i), dut.u_reg_file.regs[i], m_regs[i]);
        end
    endtask

    // Compare last edge's result, drive the next strobes, check the bus, advance the model.
    task automatic apply_cycle(ctrl_t c, alu_op_t o, word_t md);
        @(negedge clk);
        compare_state();
        ctrl    = c;
        op      = o;
        mdatain = md;
        #1;
        expect_word("bus_data", bus_data, model_bus(c));
        model_clock(c, o, md);
    endtask

    task automatic read_memory(word_t value);
        ctrl_t c;
        c = '0;
        c.mdr_in = 1'b1;
        c.read   = 1'b1;
        apply_cycle(c, op_none, value);
    endtask

    // MDR onto the bus into whatever the in strobes of dest name.
    task automatic copy_mdr(ctrl_t dest);
        ctrl_t c;
        c = dest;
        c.mdr_out = 1'b1;
        apply_cycle(c, op_none, '0);
    endtask

    task automatic load_register(int idx, word_t value);
        ctrl_t c;
        read_memory(value);
        c = '0;
        c.r_in[idx] = 1'b1;
        copy_mdr(c);
    endtask

    function automatic ctrl_t random_strobes();
        ctrl_t c;
        int    src;
        c = '0;
        c.r_in = NUM_REGS'($urandom) & NUM_REGS'($urandom); // Sparse loads.
        src = int'($urandom_range(0, 5));
        case (src)
            1: c.r_out[$urandom_range(0, NUM_REGS - 1)] = 1'b1;
            2: c.pc_out = 1'b1;
            3: c.mdr_out = 1'b1;
            4: c.zhi_out = 1'b1;
            5: c.zlo_out = 1'b1;
            default: c.r_out = '0;
        endcase
        c.pc_in  = ($urandom_range(0, 3) == 0);
        c.ir_in  = ($urandom_range(0, 3) == 0);
        c.mar_in = ($urandom_range(0, 3) == 0);
        c.mdr_in = ($urandom_range(0, 2) == 0);
        c.read   = ($urandom_range(0, 1) == 0);
        c.y_in   = ($urandom_range(0, 2) == 0);
        c.z_in   = ($urandom_range(0, 1) == 0);
        c.inc_pc = ($urandom_range(0, 7) == 0);
        return c;
    endfunction

    // Watchdog.
    initial begin
        for (int n = 0; n < MAX_CYCLES; n++) begin
            @(posedge clk);
        end
        $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        ctrl_t c;
        word_t v;
        word_t start;
        int    idx;
        void'($urandom(37));
        rst     = 1'b1;
        ctrl    = '0;
        op      = op_none;
        mdatain = '0;
        model_reset();
        for (int n = 0; n < 5; n++) begin
            @(posedge clk);
        end
        @(negedge clk);
        rst = 1'b0;
        #1;
        compare_state(); // Everything cleared.
        expect_word("bus_data after reset", bus_data, '0);

        // Memory word through MDR into a register and back onto the bus.
        idx = int'($urandom_range(4, NUM_REGS - 1));
        v = $urandom;
        load_register(idx, v);
        c = '0;
        c.r_out[idx] = 1'b1;
        apply_cycle(c, op_none, '0);
        expect_word("register on bus", bus_data, v);

        // OR instruction R1 = R2 | R3.
        load_register(2, 32'h12);
        load_register(3, 32'h14);
        read_memory(32'h3091_8000);
        c = '0;
        c.ir_in = 1'b1;
        copy_mdr(c);
        c = '0;
        c.r_out[2] = 1'b1;
        c.y_in     = 1'b1;
        apply_cycle(c, op_none, '0);
        c = '0;
        c.r_out[3] = 1'b1;
        c.z_in     = 1'b1;
        apply_cycle(c, alu_op_t'(ir[31:27]), '0); // Opcode from IR.
        c = '0;
        c.zlo_out = 1'b1;
        c.r_in[1] = 1'b1;
        apply_cycle(c, op_none, '0);
        c = '0;
        c.r_out[1] = 1'b1;
        apply_cycle(c, op_none, '0);
        expect_word("R1 after OR", bus_data, 32'h16);

        // PC increment through Z.
        start = $urandom;
        read_memory(start);
        c = '0;
        c.pc_in = 1'b1;
        copy_mdr(c);
        c = '0;
        c.pc_out = 1'b1;
        c.inc_pc = 1'b1;
        c.z_in   = 1'b1;
        apply_cycle(c, op_list[$urandom_range(0, 12)], '0); // Op must not matter.
        c = '0;
        c.zlo_out = 1'b1;
        c.pc_in   = 1'b1;
        apply_cycle(c, op_none, '0);
        apply_cycle('0, op_none, '0);
        expect_word("pc after increment", pc, start + 32'd1);

        // Every ALU code on random operands.
        foreach (op_list[k]) begin
            for (int n = 0; n < 8; n++) begin
                read_memory($urandom);
                c = '0;
                c.y_in = 1'b1;
                copy_mdr(c);
                read_memory($urandom);
                c = '0;
                c.mdr_out = 1'b1;
                c.z_in    = 1'b1;
                apply_cycle(c, op_list[k], '0);
            end
        end

        for (int n = 0; n < RANDOM_STEPS; n++) begin
            apply_cycle(random_strobes(), op_list[$urandom_range(0, 12)], $urandom);
        end
        apply_cycle('0, op_none, '0); // Picks up the last update.

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+testbench
hw/datapath_pkg.sv
hw/reg_file.sv
hw/mdr_unit.sv
hw/alu.sv
hw/bus_mux.sv
hw/datapath.sv
testbench/datapath_chk.sv
testbench/datapath_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the datapath testbench with Verilator.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module datapath_tb -f files.f \
    || { echo "Build failed"; exit 1; }
out=$(./obj_dir/Vdatapath_tb 2>&1)
echo "$out"
echo "$out" | grep -q "TEST PASSED" && exit 0 || exit 1
